// File: Makefile
# Verilator flow for the MSE engine testbench

VERILATOR ?= verilator
TOP       ?= tb_hsi_mse
FILELIST  ?= hsi_mse_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: design/hsi_mse_ctrl_pkg.sv
`default_nettype none

package hsi_mse_ctrl_pkg;

  // Run control
  typedef enum logic [1:0] {
    CTRL_IDLE   = 2'd0,  // Waiting for start
    CTRL_RUN    = 2'd1,  // Accepting sample pairs
    CTRL_DRAIN  = 2'd2,  // Last sample inside the pipeline
    CTRL_DIVIDE = 2'd3   // Divider busy on the final sum
  } ctrl_state_e;

  // Sequential divider
  typedef enum logic {
    DIV_IDLE = 1'b0,  // Ready for a new division
    DIV_ITER = 1'b1   // Shifting out quotient bits
  } div_state_e;

endpackage

`default_nettype wire

// File: design/hsi_mse_params.svh
`ifndef HSI_MSE_PARAMS_SVH
`define HSI_MSE_PARAMS_SVH

// Width relations are fixed. MUL holds a squared DATA+1 difference,
// ACC must cover the longest tiled run of squares

`define HM_DATA_WIDTH      16  // One band value, signed
`define HM_DATA_WIDTH_MUL  34  // Square of a 17-bit difference
`define HM_DATA_WIDTH_ACC  48  // Running sum of squared errors
`define HM_COUNT_WIDTH     32  // Total sample count, also divisor width

`endif

// File: design/hsi_mse_pkg.sv
`default_nettype none

`include "hsi_mse_params.svh"

package hsi_mse_pkg;

  // Band sample as delivered by the cube readers
  typedef logic signed [`HM_DATA_WIDTH-1:0] sample_t;

  // One extra bit so -32768 minus 32767 still fits
  typedef logic signed [`HM_DATA_WIDTH:0] diff_t;

  // Square is never negative
  typedef logic [`HM_DATA_WIDTH_MUL-1:0] sq_t;

  // Sum of squared errors, also reused for the MSE quotient
  typedef logic [`HM_DATA_WIDTH_ACC-1:0] acc_t;

  // Samples seen so far, including earlier tiles
  typedef logic [`HM_COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// File: design/hsi_mse_top.sv
`default_nettype none

module hsi_mse_top (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 start,
  input  wire hsi_mse_pkg::acc_t    init_sum,
  input  wire hsi_mse_pkg::count_t  init_count,
  input  wire logic                 sample_valid,
  input  wire hsi_mse_pkg::sample_t sample_a,
  input  wire hsi_mse_pkg::sample_t sample_b,
  input  wire logic                 sample_last,
  output logic                      busy,
  output logic                      sum_valid,
  output hsi_mse_pkg::acc_t         sum_out,
  output logic                      mse_valid,
  output hsi_mse_pkg::acc_t         mse_out,
  output hsi_mse_pkg::acc_t         mse_rem,
  output logic                      div_by_zero
);
  import hsi_mse_pkg::*;

  logic   div_start;     // Launch pulse from control
  logic   div_done;      // Result pulse from the divider
  acc_t   div_dividend;  // Final sum of squared errors
  count_t div_divisor;   // Total samples over all tiles

  sq_acc_if acc_bus ();  // Registered pair toward the accumulator

  mse_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .init_sum     (init_sum),
    .init_count   (init_count),
    .sample_valid (sample_valid),
    .sample_a     (sample_a),
    .sample_b     (sample_b),
    .sample_last  (sample_last),
    .acc          (acc_bus.ctrl),
    .sum_valid    (sum_valid),
    .sum_in       (sum_out),
    .div_start    (div_start),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor),
    .div_done     (div_done),
    .busy         (busy)
  );

  sq_df_acc u_acc (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc       (acc_bus.acc),
    .out_valid (sum_valid),      // Running sum also visible outside
    .out_sum   (sum_out)
  );

  mse_divider u_div (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (div_start),
    .dividend    (div_dividend),
    .divisor     (div_divisor),
    .done        (div_done),
    .quotient    (mse_out),
    .remainder   (mse_rem),
    .div_by_zero (div_by_zero)
  );

  assign mse_valid = div_done;   // Same cycle busy drops

endmodule

`default_nettype wire

// File: design/mse_ctrl.sv
`default_nettype none

module mse_ctrl (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                start,
  input  wire hsi_mse_pkg::acc_t   init_sum,
  input  wire hsi_mse_pkg::count_t init_count,
  input  wire logic                sample_valid,
  input  wire hsi_mse_pkg::sample_t sample_a,
  input  wire hsi_mse_pkg::sample_t sample_b,
  input  wire logic                sample_last,
  sq_acc_if.ctrl                   acc,
  input  wire logic                sum_valid,
  input  wire hsi_mse_pkg::acc_t   sum_in,
  output logic                     div_start,
  output hsi_mse_pkg::acc_t        div_dividend,
  output hsi_mse_pkg::count_t      div_divisor,
  input  wire logic                div_done,
  output logic                     busy
);
  import hsi_mse_pkg::*;
  import hsi_mse_ctrl_pkg::*;

  ctrl_state_e state;
  acc_t        init_sum_q;    // Resume sum for this run
  count_t      init_count_q;  // Resume count for this run
  count_t      sample_cnt;    // Pairs accepted in this run
  logic        first_pend;    // Next accepted pair opens the sum
  logic [3:0]  last_dly;      // Tracks the last pair through 4 register stages
  logic        idle_now;
  logic        launch;
  logic        accept;
  logic        last_sum;

  // Divider completion frees the engine in the same cycle
  assign idle_now = (state == CTRL_IDLE) || ((state == CTRL_DIVIDE) && div_done);
  assign busy     = !idle_now;
  assign launch   = idle_now && start;                  // Start outside idle is dropped
  assign accept   = (state == CTRL_RUN) && sample_valid;
  assign last_sum = sum_valid && last_dly[3];           // Final running sum on sum_in

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= CTRL_IDLE;
      sample_cnt <= '0;
      first_pend <= 1'b0;
      last_dly   <= '0;
      acc.valid  <= 1'b0;
      div_start  <= 1'b0;
    end else begin
      acc.valid <= accept;                              // Interface register stage
      div_start <= 1'b0;                                // Single-cycle pulse
      last_dly  <= {last_dly[2:0], accept && sample_last};
      if (launch) begin
        state      <= CTRL_RUN;
        sample_cnt <= '0;
        first_pend <= 1'b1;
      end else begin
        case (state)
          CTRL_RUN: begin
            if (accept) begin
              sample_cnt <= sample_cnt + 1'b1;
              first_pend <= 1'b0;
              if (sample_last) begin
                state <= CTRL_DRAIN;                    // Wait for the tagged sum
              end
            end
          end
          CTRL_DRAIN: begin
            if (last_sum) begin
              state     <= CTRL_DIVIDE;
              div_start <= 1'b1;
            end
          end
          CTRL_DIVIDE: begin
            if (div_done) begin
              state <= CTRL_IDLE;
            end
          end
          default: begin
            state <= CTRL_IDLE;                         // Idle holds until launch
          end
        endcase
      end
    end
  end

  // Data registers, qualified by the control strobes above
  always_ff @(posedge clk) begin
    if (launch) begin
      init_sum_q   <= init_sum;
      init_count_q <= init_count;
    end
    if (accept) begin
      acc.v1       <= sample_a;
      acc.v2       <= sample_b;
      acc.init_en  <= first_pend;                       // Only on the opening pair
      acc.init_acc <= init_sum_q;
    end
    if (last_sum) begin
      div_dividend <= sum_in;
      div_divisor  <= init_count_q + sample_cnt;        // Earlier tiles plus this one
    end
  end

  // Sample streaming only while a run is active
  a_no_sample_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) !busy |-> !sample_valid
  );

endmodule

`default_nettype wire

// File: design/mse_divider.sv
`default_nettype none

`include "hsi_mse_params.svh"

module mse_divider (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                start,
  input  wire hsi_mse_pkg::acc_t   dividend,
  input  wire hsi_mse_pkg::count_t divisor,
  output logic                     done,
  output hsi_mse_pkg::acc_t        quotient,
  output hsi_mse_pkg::acc_t        remainder,
  output logic                     div_by_zero
);
  import hsi_mse_pkg::*;
  import hsi_mse_ctrl_pkg::*;

  localparam int ITER_W = $clog2(`HM_DATA_WIDTH_ACC);
  localparam logic [ITER_W-1:0] LAST_ITER = ITER_W'(`HM_DATA_WIDTH_ACC - 1);

  div_state_e              state;
  logic [ITER_W-1:0]       iter_cnt;  // Quotient bits already produced
  count_t                  dvs_q;     // Divisor held for the whole run
  count_t                  rem_q;     // Partial remainder
  acc_t                    quo_q;     // Dividend shifting out, quotient shifting in
  count_t                  rem_cur;
  acc_t                    quo_cur;
  count_t                  dvs_cur;
  logic [`HM_COUNT_WIDTH:0] shifted;  // Remainder with next dividend bit appended
  logic [`HM_COUNT_WIDTH:0] trial;
  count_t                  rem_nxt;
  acc_t                    quo_nxt;
  logic                    load;
  logic                    zero_div;
  logic                    finish;

  assign load     = start && (state == DIV_IDLE);
  assign zero_div = (divisor == '0);
  assign finish   = (state == DIV_ITER) && (iter_cnt == LAST_ITER);

  // One restoring step, the first one fed straight from the inputs
  always_comb begin
    rem_cur = (state == DIV_IDLE) ? '0 : rem_q;
    quo_cur = (state == DIV_IDLE) ? dividend : quo_q;
    dvs_cur = (state == DIV_IDLE) ? divisor : dvs_q;
    shifted = {rem_cur, quo_cur[`HM_DATA_WIDTH_ACC-1]};
    trial   = shifted - {1'b0, dvs_cur};
    if (!trial[`HM_COUNT_WIDTH]) begin                   // No borrow, subtract fits
      rem_nxt = trial[`HM_COUNT_WIDTH-1:0];
      quo_nxt = {quo_cur[`HM_DATA_WIDTH_ACC-2:0], 1'b1};
    end else begin                                       // Restore
      rem_nxt = shifted[`HM_COUNT_WIDTH-1:0];
      quo_nxt = {quo_cur[`HM_DATA_WIDTH_ACC-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= DIV_IDLE;
      iter_cnt    <= '0;
      done        <= 1'b0;
      div_by_zero <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (load) begin
            div_by_zero <= zero_div;
            if (zero_div) begin
              done <= 1'b1;                              // Shortcut, answer next cycle
            end else begin
              state    <= DIV_ITER;
              iter_cnt <= ITER_W'(1);                    // First bit done on load
            end
          end
        end
        default: begin
          if (finish) begin
            state <= DIV_IDLE;
            done  <= 1'b1;
          end else begin
            iter_cnt <= iter_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load || (state == DIV_ITER)) begin
      rem_q <= rem_nxt;
      quo_q <= quo_nxt;
    end
    if (load) begin
      dvs_q <= divisor;
    end
    if (load && zero_div) begin
      quotient  <= '1;                                   // Saturated result
      remainder <= dividend;
    end else if (finish) begin
      quotient  <= quo_nxt;
      remainder <= acc_t'(rem_nxt);
    end
  end

  // Controller must wait for done before the next division
  a_no_restart: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> state == DIV_IDLE
  );

endmodule

`default_nettype wire

// File: design/sq_acc_if.sv
`default_nettype none

// One registered sample pair plus its accumulator-load command
interface sq_acc_if;
  import hsi_mse_pkg::*;

  logic    valid;     // Pair present this cycle
  sample_t v1;        // Reference cube sample
  sample_t v2;        // Reconstructed cube sample
  logic    init_en;   // First pair of the run
  acc_t    init_acc;  // Partial sum to resume from

  modport ctrl (
    output valid,
    output v1,
    output v2,
    output init_en,
    output init_acc
  );

  modport acc (
    input valid,
    input v1,
    input v2,
    input init_en,
    input init_acc
  );

endinterface

`default_nettype wire

// File: design/sq_df_acc.sv
`default_nettype none

module sq_df_acc (
  input  wire logic         clk,
  input  wire logic         rst_n,
  sq_acc_if.acc             acc,
  output logic              out_valid,
  output hsi_mse_pkg::acc_t out_sum
);
  import hsi_mse_pkg::*;

  logic  en_1;    // Stage 1 holds a difference
  logic  en_2;    // Stage 2 holds a square
  logic  init_1;  // Opening pair in stage 1
  logic  init_2;  // Opening pair in stage 2
  acc_t  acc_1;   // Resume value riding along stage 1
  acc_t  acc_2;   // Resume value riding along stage 2
  diff_t diff;
  sq_t   mult;

  // Valid and load flags walk the pipe with their data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_1      <= 1'b0;
      en_2      <= 1'b0;
      init_1    <= 1'b0;
      init_2    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      en_1      <= acc.valid;
      init_1    <= acc.valid && acc.init_en;  // Load command only counts with valid
      en_2      <= en_1;
      init_2    <= en_1 && init_1;
      out_valid <= en_2;
    end
  end

  always_ff @(posedge clk) begin
    // Stage 1
    if (acc.valid) begin
      diff  <= acc.v1 - acc.v2;               // 17-bit, no wrap
      acc_1 <= acc.init_acc;
    end
    // Stage 2
    if (en_1) begin
      mult  <= diff * diff;                   // Max 2^32, fits 34 bits
      acc_2 <= acc_1;
    end
    // Stage 3
    if (en_2) begin
      if (init_2) begin
        out_sum <= acc_2 + mult;              // Start from the resume value
      end else begin
        out_sum <= out_sum + mult;            // Keep accumulating
      end
    end
  end

  // Fixed three-cycle latency through the pipe
  a_out_latency: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid == $past(acc.valid, 3)
  );

endmodule

`default_nettype wire

// File: hsi_mse_top.f
+incdir+design
design/hsi_mse_pkg.sv
design/hsi_mse_ctrl_pkg.sv
design/sq_acc_if.sv
design/mse_ctrl.sv
design/sq_df_acc.sv
design/mse_divider.sv
design/hsi_mse_top.sv
tb/tb_hsi_mse.sv

// File: tb/mse_golden.txt
# Case line: init_sum init_count n, then n pair lines: a b (16-bit two's complement)
# Result line: gap_max exp_sum exp_quotient exp_remainder exp_div_by_zero, all hex
# Plain run, back to back
0 0 4
000a 0003
fffb 0005
0064 0064
0007 fffe
0 e6 39 2 0
# Random gaps up to 3 cycles
0 0 5
03e8 03de
fed4 feca
0000 ffff
0002 0002
0032 0014
3 44d dc 1 0
# Resume from a partial tile
1000 a 3
0003 0000
fffc 0000
0000 000c
2 10a9 148 1 0
# Extreme differences
0 0 3
8000 7fff
7fff 8000
8000 8000
1 1fffc0002 aaa95556 0 0
# Large resume sum
7fff00000000 fffe 2
8000 7fff
0000 0000
0 7ffffffe0001 7ffffffe 1 0
# Single sample, divisor one
0 0 1
0014 ffec
0 640 640 0 0
# Count wraps to zero
5 ffffffff 1
0001 0000
2 6 ffffffffffff 6 1
# Normal run after the zero divisor
40 2 2
0100 0000
ff00 0000
2 20040 8010 0 0

// File: tb/tb_hsi_mse.sv
`default_nettype none

module tb_hsi_mse;
  import hsi_mse_pkg::*;

  localparam int WAIT_MAX = 200;        // Cycle bound on every wait

  logic    clk = 1'b0;
  logic    rst_n;
  logic    start;
  acc_t    init_sum;
  count_t  init_count;
  logic    sample_valid;
  sample_t sample_a;
  sample_t sample_b;
  logic    sample_last;
  logic    busy;
  logic    sum_valid;
  acc_t    sum_out;
  logic    mse_valid;
  acc_t    mse_out;
  acc_t    mse_rem;
  logic    div_by_zero;

  int          cyc_cnt = 0;             // Rising edges so far
  int          last_sum_cyc = 0;        // Edge count at the latest sum_valid
  int          due_cyc;
  acc_t        due_sum;
  logic [31:0] lcg_state = 32'h1376_0dd1;
  acc_t        exp_sum_q[$];            // Running sums still in the pipe
  int          exp_cyc_q[$];            // Edge count each sum is due at
  logic [15:0] pair_a[$];               // Reference samples of the case
  logic [15:0] pair_b[$];               // Reconstructed samples of the case
  int          fd;

  hsi_mse_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .init_sum     (init_sum),
    .init_count   (init_count),
    .sample_valid (sample_valid),
    .sample_a     (sample_a),
    .sample_b     (sample_b),
    .sample_last  (sample_last),
    .busy         (busy),
    .sum_valid    (sum_valid),
    .sum_out      (sum_out),
    .mse_valid    (mse_valid),
    .mse_out      (mse_out),
    .mse_rem      (mse_rem),
    .div_by_zero  (div_by_zero)
  );

  always #50 clk = ~clk;                // Period 100

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("Run aborted: %s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
    return lcg_state;
  endfunction

  // Drive slot, a little after the rising edge
  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  // Next data line, comments and blank lines skipped, empty at end of file
  task automatic read_line(output string line);
    int rc;
    line = "";
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1 && line[0] != "#") begin
        return;
      end
      line = "";
    end
  endtask

  // Every sum_valid must match the oldest sample in flight, on time
  always @(negedge clk) begin
    if (rst_n && sum_valid) begin
      if (exp_sum_q.size() == 0) begin
        stop_run("sum_valid rose with no sample in flight");
      end else begin
        due_cyc = exp_cyc_q.pop_front();
        due_sum = exp_sum_q.pop_front();
        check_val("sum_valid edge", 64'(cyc_cnt), 64'(due_cyc));
        check_val("sum_out", 64'(sum_out), 64'(due_sum));
        last_sum_cyc = cyc_cnt;
      end
    end
  end

  task automatic run_case(input acc_t i_sum, input count_t i_cnt, input int gap_max,
                          input acc_t g_sum, input acc_t g_quo, input acc_t g_rem,
                          input logic g_dbz);
    acc_t   run_sum;
    count_t dvs;
    longint d;
    int     gap;
    int     waited;
    int     exp_lat;
    run_sum = i_sum;
    dvs     = i_cnt + count_t'(pair_a.size());          // Wraps like the hardware count
    exp_lat = (dvs == '0) ? 2 : 49;                      // Launch pulse plus 1 or 48 cycles
    tick();
    start      = 1'b1;
    init_sum   = i_sum;
    init_count = i_cnt;
    tick();
    start = 1'b0;
    check_val("busy", 64'(busy), 64'd1);
    foreach (pair_a[i]) begin
      gap = (gap_max == 0) ? 0 : int'(next_rand() >> 16) % (gap_max + 1);
      repeat (gap) tick();                               // Idle cycles inside the run
      d       = longint'($signed(pair_a[i])) - longint'($signed(pair_b[i]));
      run_sum = run_sum + acc_t'(d * d);
      sample_valid = 1'b1;
      sample_a     = pair_a[i];
      sample_b     = pair_b[i];
      sample_last  = (i == pair_a.size() - 1);
      exp_cyc_q.push_back(cyc_cnt + 4);                  // Sum due 4 edges after this slot
      exp_sum_q.push_back(run_sum);
      tick();
      sample_valid = 1'b0;
      sample_last  = 1'b0;
    end
    // Stray start and samples while draining
    start        = 1'b1;
    sample_valid = 1'b1;
    init_sum     = ~i_sum;
    init_count   = ~i_cnt;
    sample_a     = 16'sh7fff;
    sample_b     = 16'sh8000;
    repeat (2) tick();
    start        = 1'b0;
    sample_valid = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (!mse_valid) begin
        check_val("busy", 64'(busy), 64'd1);             // Held until the result
        if (waited >= WAIT_MAX) begin
          stop_run("mse_valid did not arrive within 200 cycles");
        end
      end
    end while (!mse_valid);
    check_val("golden sum", 64'(g_sum), 64'(run_sum));
    check_val("sum_out", 64'(sum_out), 64'(run_sum));
    check_val("mse_out", 64'(mse_out), 64'(g_quo));
    check_val("mse_rem", 64'(mse_rem), 64'(g_rem));
    check_val("div_by_zero", 64'(div_by_zero), 64'(dvs == '0));
    check_val("golden div_by_zero", 64'(g_dbz), 64'(dvs == '0));
    check_val("busy", 64'(busy), 64'd0);                 // Falls with mse_valid
    check_val("pending sums", 64'(exp_sum_q.size()), 64'd0);
    check_val("mse_valid delay", 64'(cyc_cnt - last_sum_cyc), 64'(exp_lat));
  endtask

  initial begin
    string       line;
    acc_t        g_init_sum;
    count_t      g_init_cnt;
    acc_t        g_sum;
    acc_t        g_quo;
    acc_t        g_rem;
    logic        g_dbz;
    logic [15:0] a;
    logic [15:0] b;
    int          n;
    int          gap_max;
    int          n_case;
    int          rc;
    rst_n        = 1'b0;
    start        = 1'b0;
    init_sum     = '0;
    init_count   = '0;
    sample_valid = 1'b0;
    sample_a     = '0;
    sample_b     = '0;
    sample_last  = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_val("busy", 64'(busy), 64'd0);
    check_val("sum_valid", 64'(sum_valid), 64'd0);
    check_val("mse_valid", 64'(mse_valid), 64'd0);
    fd = $fopen("tb/mse_golden.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open tb/mse_golden.txt");
    end
    n_case = 0;
    read_line(line);
    while (line.len() > 0) begin
      rc = $sscanf(line, "%h %h %h", g_init_sum, g_init_cnt, n);
      if (rc != 3) begin
        stop_run("malformed case line in the golden file");
      end
      pair_a.delete();
      pair_b.delete();
      repeat (n) begin
        read_line(line);
        rc = $sscanf(line, "%h %h", a, b);
        if (rc != 2) begin
          stop_run("malformed sample pair in the golden file");
        end
        pair_a.push_back(a);
        pair_b.push_back(b);
      end
      read_line(line);
      rc = $sscanf(line, "%h %h %h %h %h", gap_max, g_sum, g_quo, g_rem, g_dbz);
      if (rc != 5) begin
        stop_run("malformed result line in the golden file");
      end
      run_case(g_init_sum, g_init_cnt, gap_max, g_sum, g_quo, g_rem, g_dbz);
      n_case++;
      read_line(line);
    end
    $fclose(fd);
    if (n_case == 0 || exp_sum_q.size() != 0) begin
      stop_run("no case was run or sums were left over");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
